// File: bus_pkg.sv
package bus_pkg;

   // host side widths
   typedef logic [31:0] bus_addr_t;   // byte address
   typedef logic [31:0] bus_word_t;   // data word
   typedef logic [2:0]  word_idx_t;   // word within a line

   // address window of the bridge
   localparam bus_addr_t BUS_BASE_ADDR    = 32'h1000_0000;
   localparam bus_addr_t BUS_WINDOW_BYTES = 32'h0010_0000;  // 1 MiB
   localparam bus_addr_t BUS_END_ADDR     = BUS_BASE_ADDR + BUS_WINDOW_BYTES;

   // line layout, only the low eight words of a beat are mapped
   localparam int LINE_BYTES     = 32;
   localparam int WORDS_PER_LINE = 8;

   // offset bit positions
   localparam int WORD_SHIFT = $clog2(LINE_BYTES / WORDS_PER_LINE);  // byte within word
   localparam int LINE_SHIFT = $clog2(LINE_BYTES);                   // word within line

endpackage

// File: dram_pkg.sv
package dram_pkg;

   // controller user port widths
   typedef logic [31:0]  dram_addr_t;
   typedef logic [287:0] dram_beat_t;   // 8 data words + 32 extra bits
   typedef logic [2:0]   dram_cmd_t;

   // command codes
   localparam dram_cmd_t DRAM_CMD_NONE = 3'd0;
   localparam dram_cmd_t DRAM_CMD_READ = 3'd1;

   // read sequencer
   typedef enum logic [1:0] {
      RD_IDLE = 2'd0,   // waiting for rd_start
      RD_CMD  = 2'd1,   // command on the port, waiting for dram_rdy
      RD_WAIT = 2'd2    // waiting for the read burst
   } rd_state_t;

endpackage

// File: bus_slave.sv
`timescale 1ns/1ps

module bus_slave (
   input  logic                 dram_clk,
   input  logic                 dram_rst,
   input  logic                 req_valid,
   input  bus_pkg::bus_addr_t   req_addr,
   input  logic                 rsp_valid,
   output logic                 busy,
   output logic                 rd_start,
   output dram_pkg::dram_addr_t line_addr,
   output bus_pkg::word_idx_t   word_idx
);

   import bus_pkg::*;
   import dram_pkg::*;

   logic      in_window;
   logic      accept;
   bus_addr_t offset;

   // window check on the raw address
   assign in_window = (req_addr >= BUS_BASE_ADDR) && (req_addr < BUS_END_ADDR);

   // strobes while busy or outside the window are dropped
   assign accept = req_valid && !busy && in_window;

   assign offset = req_addr - BUS_BASE_ADDR;

   // one read in flight at a time
   always_ff @(posedge dram_clk) begin
      if (dram_rst) begin
         busy     <= 1'b0;
         rd_start <= 1'b0;
      end else begin
         rd_start <= accept;   // single cycle pulse
         if (accept) begin
            busy <= 1'b1;
         end else if (rsp_valid) begin
            busy <= 1'b0;      // free again on the cycle after the response
         end
      end
   end

   // request fields, held until the next accepted request
   always_ff @(posedge dram_clk) begin
      if (accept) begin
         line_addr <= dram_addr_t'(offset >> LINE_SHIFT);
         word_idx  <= offset[LINE_SHIFT-1:WORD_SHIFT];
      end
   end

endmodule

// File: dram_rd_seq.sv
`timescale 1ns/1ps

module dram_rd_seq (
   input  logic                 dram_clk,
   input  logic                 dram_rst,
   input  logic                 rd_start,
   input  dram_pkg::dram_addr_t line_addr,
   output logic                 line_done,
   output dram_pkg::dram_beat_t line_data,
   output dram_pkg::dram_addr_t dram_addr,
   output dram_pkg::dram_cmd_t  dram_cmd,
   output logic                 dram_en,
   input  logic                 dram_rdy,
   input  dram_pkg::dram_beat_t dram_rd_data,
   input  logic                 dram_rd_data_valid,
   input  logic                 dram_rd_data_end
);

   import dram_pkg::*;

   rd_state_t state;
   logic      beat_held;   // first beat of the burst already stored
   logic      capture;
   logic      burst_end;

   // keep only the first beat, the end beat is the inverse copy
   assign capture = (state == RD_WAIT) && dram_rd_data_valid
                    && !dram_rd_data_end && !beat_held;

   assign burst_end = (state == RD_WAIT) && dram_rd_data_valid && dram_rd_data_end;

   always_ff @(posedge dram_clk) begin
      if (dram_rst) begin
         state     <= RD_IDLE;
         beat_held <= 1'b0;
         line_done <= 1'b0;
         dram_en   <= 1'b0;
         dram_cmd  <= DRAM_CMD_NONE;
         dram_addr <= '0;
      end else begin
         line_done <= 1'b0;

         case (state)
            RD_IDLE: begin
               beat_held <= 1'b0;
               if (rd_start) begin
                  // put the read on the user port
                  dram_en   <= 1'b1;
                  dram_cmd  <= DRAM_CMD_READ;
                  dram_addr <= line_addr;
                  state     <= RD_CMD;
               end
            end

            RD_CMD: begin
               // en, cmd and addr stay put until the controller takes them
               if (dram_rdy) begin
                  dram_en   <= 1'b0;
                  dram_cmd  <= DRAM_CMD_NONE;
                  dram_addr <= '0;
                  state     <= RD_WAIT;
               end
            end

            RD_WAIT: begin
               if (capture) begin
                  beat_held <= 1'b1;
               end
               if (burst_end) begin
                  line_done <= 1'b1;   // line_data is stable from here on
                  beat_held <= 1'b0;
                  state     <= RD_IDLE;
               end
            end

            default: begin
               state <= RD_IDLE;
            end
         endcase
      end
   end

   // beat store
   always_ff @(posedge dram_clk) begin
      if (capture) begin
         line_data <= dram_rd_data;
      end
   end

endmodule

// File: word_select.sv
`timescale 1ns/1ps

module word_select (
   input  logic                 dram_clk,
   input  logic                 dram_rst,
   input  logic                 line_done,
   input  dram_pkg::dram_beat_t line_data,
   input  bus_pkg::word_idx_t   word_idx,
   output logic                 rsp_valid,
   output bus_pkg::bus_word_t   rsp_data
);

   import bus_pkg::*;

   bus_word_t line_words [WORDS_PER_LINE];

   // word k sits at bits 32k upward, top 32 bits of the beat unused
   always_comb begin
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
         line_words[k] = line_data[k*$bits(bus_word_t) +: $bits(bus_word_t)];
      end
   end

   always_ff @(posedge dram_clk) begin
      if (dram_rst) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= line_done;   // one cycle after line_done
      end
   end

   // held until the next response
   always_ff @(posedge dram_clk) begin
      if (line_done) begin
         rsp_data <= line_words[word_idx];
      end
   end

endmodule

// File: dram_bridge_top.sv
`timescale 1ns/1ps

module dram_bridge_top (
   input  logic                 dram_clk,
   input  logic                 dram_rst,

   // host side
   input  logic                 req_valid,
   input  bus_pkg::bus_addr_t   req_addr,
   output logic                 busy,
   output logic                 rsp_valid,
   output bus_pkg::bus_word_t   rsp_data,

   // controller user port
   output dram_pkg::dram_addr_t dram_addr,
   output dram_pkg::dram_cmd_t  dram_cmd,
   output logic                 dram_en,
   input  logic                 dram_rdy,
   input  dram_pkg::dram_beat_t dram_rd_data,
   input  logic                 dram_rd_data_valid,
   input  logic                 dram_rd_data_end
);

   import bus_pkg::*;
   import dram_pkg::*;

   logic       rd_start;
   dram_addr_t line_addr;
   word_idx_t  word_idx;
   logic       line_done;
   dram_beat_t line_data;

   bus_slave i_bus_slave (
      .dram_clk  (dram_clk),
      .dram_rst  (dram_rst),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .rsp_valid (rsp_valid),   // clears busy
      .busy      (busy),
      .rd_start  (rd_start),
      .line_addr (line_addr),
      .word_idx  (word_idx)
   );

   dram_rd_seq i_dram_rd_seq (
      .dram_clk           (dram_clk),
      .dram_rst           (dram_rst),
      .rd_start           (rd_start),
      .line_addr          (line_addr),
      .line_done          (line_done),
      .line_data          (line_data),
      .dram_addr          (dram_addr),
      .dram_cmd           (dram_cmd),
      .dram_en            (dram_en),
      .dram_rdy           (dram_rdy),
      .dram_rd_data       (dram_rd_data),
      .dram_rd_data_valid (dram_rd_data_valid),
      .dram_rd_data_end   (dram_rd_data_end)
   );

   word_select i_word_select (
      .dram_clk  (dram_clk),
      .dram_rst  (dram_rst),
      .line_done (line_done),
      .line_data (line_data),
      .word_idx  (word_idx),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data)
   );

endmodule

// File: dram_model.sv
`timescale 1ns/1ps

module dram_model #(
   parameter int SEED = 32'h630e1422
) (
   input  logic                 dram_clk,
   input  dram_pkg::dram_addr_t dram_addr,
   input  dram_pkg::dram_cmd_t  dram_cmd,
   input  logic                 dram_en,
   output logic                 dram_rdy,
   output dram_pkg::dram_beat_t dram_rd_data,
   output logic                 dram_rd_data_valid,
   output logic                 dram_rd_data_end
);

   import bus_pkg::*;
   import dram_pkg::*;

   integer     seed;
   int         delay;
   dram_addr_t line_no;
   dram_beat_t beat;

   // word k of line L holds L*8+k, top word all ones
   function automatic dram_beat_t first_beat(input dram_addr_t line);
      dram_beat_t b;
      b = '1;
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
         b[k*32 +: 32] = line * 8 + k;
      end
      return b;
   endfunction

   // user port side, everything changes on the falling edge
   initial begin
      seed               = SEED;
      dram_rdy           = 1'b0;
      dram_rd_data       = '0;
      dram_rd_data_valid = 1'b0;
      dram_rd_data_end   = 1'b0;
      forever begin
         @(negedge dram_clk);
         if (dram_en && dram_cmd == DRAM_CMD_READ) begin
            line_no = dram_addr;
            delay   = $unsigned($random(seed)) % 4;   // 0 to 3 cycles to ready
            repeat (delay) @(negedge dram_clk);
            dram_rdy = 1'b1;
            @(negedge dram_clk);
            dram_rdy = 1'b0;
            // read latency, one cycle here plus 0 to 3 more
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(negedge dram_clk);
            beat               = first_beat(line_no);
            dram_rd_data       = beat;
            dram_rd_data_valid = 1'b1;
            dram_rd_data_end   = 1'b0;
            @(negedge dram_clk);
            dram_rd_data     = ~beat;   // end beat is the inverse
            dram_rd_data_end = 1'b1;
            @(negedge dram_clk);
            dram_rd_data       = '0;
            dram_rd_data_valid = 1'b0;
            dram_rd_data_end   = 1'b0;
         end
      end
   end

endmodule

// File: tb_dram_bridge.sv
`timescale 1ns/1ps

module tb_dram_bridge;

   import bus_pkg::*;
   import dram_pkg::*;

   localparam int SEED         = 32'h630e1422;
   localparam int RANDOM_READS = 50;
   localparam int TOTAL_REQS   = 8 + RANDOM_READS + 4 + 4;   // all strobes of all tests
   localparam int CYCLE_LIMIT  = 40 * TOTAL_REQS + 200;

   logic       dram_clk;
   logic       dram_rst;
   logic       req_valid;
   bus_addr_t  req_addr;
   logic       busy;
   logic       rsp_valid;
   bus_word_t  rsp_data;
   dram_addr_t dram_addr;
   dram_cmd_t  dram_cmd;
   logic       dram_en;
   logic       dram_rdy;
   dram_beat_t dram_rd_data;
   logic       dram_rd_data_valid;
   logic       dram_rd_data_end;

   integer seed;
   string  test_name;
   int     rsp_count   = 0;
   int     cycle_count = 0;

   dram_bridge_top i_dut (
      .dram_clk           (dram_clk),
      .dram_rst           (dram_rst),
      .req_valid          (req_valid),
      .req_addr           (req_addr),
      .busy               (busy),
      .rsp_valid          (rsp_valid),
      .rsp_data           (rsp_data),
      .dram_addr          (dram_addr),
      .dram_cmd           (dram_cmd),
      .dram_en            (dram_en),
      .dram_rdy           (dram_rdy),
      .dram_rd_data       (dram_rd_data),
      .dram_rd_data_valid (dram_rd_data_valid),
      .dram_rd_data_end   (dram_rd_data_end)
   );

   dram_model #(
      .SEED (SEED)
   ) i_dram_model (
      .dram_clk           (dram_clk),
      .dram_addr          (dram_addr),
      .dram_cmd           (dram_cmd),
      .dram_en            (dram_en),
      .dram_rdy           (dram_rdy),
      .dram_rd_data       (dram_rd_data),
      .dram_rd_data_valid (dram_rd_data_valid),
      .dram_rd_data_end   (dram_rd_data_end)
   );

   always #50 dram_clk = ~dram_clk;   // 100 ns period

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_equal(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         abort_run($sformatf("FAILED %s %s: expected %h, actual %h",
                             test_name, what, expected, actual));
      end
   endtask

   // one-cycle strobe, called on a falling edge
   task automatic issue_request(input bus_addr_t addr);
      req_valid = 1'b1;
      req_addr  = addr;
      @(negedge dram_clk);
      req_valid = 1'b0;
   endtask

   task automatic await_response(output bus_word_t value);
      do begin
         @(negedge dram_clk);
      end while (!rsp_valid);
      value = rsp_data;
   endtask

   // nothing may happen on either side
   task automatic watch_idle(input int cycles);
      repeat (cycles) begin
         check_equal("dram_en", 32'd0, 32'(dram_en));
         check_equal("busy", 32'd0, 32'(busy));
         check_equal("rsp_valid", 32'd0, 32'(rsp_valid));
         @(negedge dram_clk);
      end
   endtask

   task automatic read_and_check(input bus_addr_t addr);
      bus_addr_t offset;
      bus_word_t expected;
      bus_word_t value;
      int        count_before;
      offset       = addr - BUS_BASE_ADDR;
      expected     = offset / 4;   // word address in the window
      count_before = rsp_count;
      issue_request(addr);
      check_equal("busy after accept", 32'd1, 32'(busy));
      while (!dram_en) begin
         @(negedge dram_clk);
      end
      check_equal("dram_cmd", 32'(DRAM_CMD_READ), 32'(dram_cmd));
      check_equal("dram_addr", offset / LINE_BYTES, dram_addr);
      await_response(value);
      check_equal("rsp_data", expected, value);   // end beat would hold the inverse
      @(negedge dram_clk);
      check_equal("busy after rsp_valid", 32'd0, 32'(busy));
      check_equal("response count", 32'(count_before + 1), 32'(rsp_count));
   endtask

   always @(posedge dram_clk) begin
      if (!dram_rst && rsp_valid) begin
         rsp_count <= rsp_count + 1;
      end
   end

   always @(posedge dram_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         abort_run($sformatf("timeout after %0d cycles, the run never finished", CYCLE_LIMIT));
      end
   end

   // command must sit on the port until the controller takes it
   cmd_hold_check: assert property (@(posedge dram_clk) disable iff (dram_rst)
      dram_en && !dram_rdy |=> dram_en && $stable(dram_cmd) && $stable(dram_addr))
      else abort_run("dram_en, dram_cmd or dram_addr changed before dram_rdy");

   cmd_code_check: assert property (@(posedge dram_clk) disable iff (dram_rst)
      dram_en |-> dram_cmd == DRAM_CMD_READ)
      else abort_run("dram_en was high without the read command code");

   rsp_strobe_check: assert property (@(posedge dram_clk) disable iff (dram_rst)
      rsp_valid |=> !rsp_valid && !busy)
      else abort_run("rsp_valid lasted more than one cycle or busy stayed high after it");

   initial begin
      bus_addr_t line_base;
      bus_addr_t addr;
      bus_word_t value;
      bus_addr_t out_addrs [4];
      int        count_before;
      seed      = SEED;
      dram_clk  = 1'b0;
      dram_rst  = 1'b1;
      req_valid = 1'b0;
      req_addr  = '0;
      repeat (10) @(negedge dram_clk);
      dram_rst = 1'b0;

      test_name = "reset_values";
      check_equal("busy", 32'd0, 32'(busy));
      check_equal("rsp_valid", 32'd0, 32'(rsp_valid));
      check_equal("dram_en", 32'd0, 32'(dram_en));
      check_equal("dram_cmd", 32'(DRAM_CMD_NONE), 32'(dram_cmd));

      test_name = "every_word_index";
      line_base = BUS_BASE_ADDR + 32'h0004_5660;   // line aligned
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
         read_and_check(line_base + 32'(4 * k));
      end

      test_name = "random_reads";
      repeat (RANDOM_READS) begin
         addr = BUS_BASE_ADDR + ($unsigned($random(seed)) % BUS_WINDOW_BYTES);
         read_and_check(addr);
      end

      test_name    = "out_of_window";
      out_addrs[0] = BUS_BASE_ADDR - 32'd4;
      out_addrs[1] = 32'h0000_0000;
      out_addrs[2] = BUS_BASE_ADDR + BUS_WINDOW_BYTES;   // first byte past the window
      out_addrs[3] = 32'hffff_fffc;
      foreach (out_addrs[i]) begin
         issue_request(out_addrs[i]);
         watch_idle(20);
      end

      test_name    = "requests_while_busy";
      addr         = BUS_BASE_ADDR + 32'h0000_2468;
      count_before = rsp_count;
      issue_request(addr);
      for (int i = 1; i <= 3; i++) begin
         check_equal("busy before extra strobe", 32'd1, 32'(busy));
         issue_request(addr + 32'(i * 256));
      end
      await_response(value);
      check_equal("rsp_data", (addr - BUS_BASE_ADDR) / 4, value);
      @(negedge dram_clk);
      check_equal("busy after rsp_valid", 32'd0, 32'(busy));
      check_equal("response count", 32'(count_before + 1), 32'(rsp_count));
      watch_idle(20);   // ignored strobes must not come back later

      $display("TEST OK");
      $finish;
   end

endmodule

// File: filelist.f
bus_pkg.sv
dram_pkg.sv
bus_slave.sv
dram_rd_seq.sv
word_select.sv
dram_bridge_top.sv
dram_model.sv
tb_dram_bridge.sv

// File: Makefile
SRCS := $(shell grep '\.sv$$' filelist.f)

.PHONY: all run clean

all: obj_dir/Vtb_dram_bridge

obj_dir/Vtb_dram_bridge: filelist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_dram_bridge -f filelist.f

run: obj_dir/Vtb_dram_bridge
	./obj_dir/Vtb_dram_bridge

clean:
	rm -rf obj_dir
